/* uart_reg_pkg.sv */
`default_nettype none

package uart_reg_pkg;

   // processor bus widths
   localparam int data_width = 32;
   localparam int addr_width = 3;

   //////////////////////////////
   // register map
   //////////////////////////////

   localparam logic [addr_width-1:0] uart_write_wait = 3'd0;
   localparam logic [addr_width-1:0] uart_div        = 3'd1;
   localparam logic [addr_width-1:0] uart_data       = 3'd2;
   localparam logic [addr_width-1:0] uart_soft_reset = 3'd3;
   localparam logic [addr_width-1:0] uart_read_valid = 3'd4;
   localparam logic [addr_width-1:0] uart_rxen       = 3'd5;

   //////////////////////////////
   // write data views
   //////////////////////////////

   // byte to send, low 8 bits of the word
   typedef struct packed {
      logic [data_width-9:0] pad;
      logic [7:0]            tx_byte;
   } uart_tx_view_t;

   // single control bit in bit 0
   typedef struct packed {
      logic [data_width-2:0] pad;
      logic                  flag;
   } uart_flag_view_t;

   // meaning depends on the address written
   typedef union packed {
      logic [data_width-1:0] divider;
      uart_tx_view_t         tx;
      uart_flag_view_t       ctrl;
   } uart_wdata_u;

endpackage

`default_nettype wire

/* uart_frame_pkg.sv */
`default_nettype none

package uart_frame_pkg;

   // 8N1 frame: start, eight data bits, stop
   localparam int frame_bits = 10;
   localparam int byte_bits  = 8;

   // line level between frames, also the stop bit
   localparam logic line_idle = 1'b1;

   // receiver sequence; data bit position kept apart
   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_e;

endpackage

`default_nettype wire

/* uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs #(
   parameter int div_width = 16
) (
   input  wire logic                                 clk,
   input  wire logic                                 rst_int,
   input  wire logic                                 serial_rst,
   input  wire logic                                 valid,
   input  wire logic [uart_reg_pkg::addr_width-1:0]  address,
   input  wire uart_reg_pkg::uart_wdata_u            wdata,
   input  wire logic                                 wstrb,
   output logic      [uart_reg_pkg::data_width-1:0]  rdata,
   output logic                                      ready,
   output logic                                      soft_rst,
   output logic                                      rx_en,
   output logic                                      rts,
   output logic                                      tx_load,
   output logic                                      rx_read,
   output logic      [div_width-1:0]                 divider,
   output logic      [7:0]                           tx_byte,
   input  wire logic                                 rx_valid,
   input  wire logic                                 rx_rts_ok,
   input  wire logic [7:0]                           rx_byte,
   input  wire logic                                 tx_busy,
   input  wire logic                                 cts
);

   import uart_reg_pkg::*;

   logic       wr_en;
   logic       div_wr;
   logic       soft_wr;
   logic       rxen_wr;
   logic [1:0] cts_sync;

   //////////////////////////////
   // address decoder
   //////////////////////////////

   assign wr_en = valid & wstrb;

   always_comb begin
      div_wr  = 1'b0;
      soft_wr = 1'b0;
      rxen_wr = 1'b0;
      tx_load = 1'b0;
      if (wr_en) begin
         case (address)
            uart_div:        div_wr  = 1'b1;
            uart_data:       tx_load = 1'b1;
            uart_soft_reset: soft_wr = 1'b1;
            uart_rxen:       rxen_wr = 1'b1;
            default: ;
         endcase
      end
   end

   // a plain read of the data register empties the rx buffer
   assign rx_read = valid & ~wstrb & (address == uart_data);

   assign tx_byte = wdata.tx.tx_byte;

   // read mux, combinational from address
   always_comb begin
      rdata = '0;
      case (address)
         uart_write_wait: rdata[0] = tx_busy | ~cts_sync[1];
         uart_div:        rdata[div_width-1:0] = divider;
         uart_data:       rdata[7:0] = rx_byte;
         uart_read_valid: rdata[0] = rx_valid;
         uart_rxen:       rdata[0] = rx_en;
         default: ;
      endcase
   end

   //////////////////////////////
   // control registers
   //////////////////////////////

   // bus handshake
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

   // one-cycle pulse on a write of 1
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_rst <= 1'b0;
      end else begin
         soft_rst <= soft_wr & wdata.ctrl.flag;
      end
   end

   // bit period in clock cycles
   always_ff @(posedge clk or posedge serial_rst) begin
      if (serial_rst) begin
         divider <= div_width'(1);
      end else if (div_wr) begin
         divider <= wdata.divider[div_width-1:0];
      end
   end

   always_ff @(posedge clk or posedge serial_rst) begin
      if (serial_rst) begin
         rx_en <= 1'b0;
      end else if (rxen_wr) begin
         rx_en <= wdata.ctrl.flag;
      end
   end

   //////////////////////////////
   // flow control
   //////////////////////////////

   // two-flop synchronizer
   always_ff @(posedge clk) begin
      cts_sync <= {cts_sync[0], cts};
   end

   // ask for data only when rx is on and the buffer is free
   assign rts = rx_rts_ok & rx_en;

   // every access is acknowledged on the next cycle
   a_ready_follows_valid: assert property (
      @(posedge clk) disable iff (rst_int) ready == $past(valid)
   );

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int div_width = 16
) (
   input  wire logic                                  clk,
   input  wire logic                                  rst_int,
   input  wire logic                                  tx_load,
   input  wire logic [uart_frame_pkg::byte_bits-1:0]  tx_byte,
   input  wire logic [div_width-1:0]                  divider,
   output logic                                       txd,
   output logic                                       tx_busy
);

   import uart_frame_pkg::*;

   localparam int cnt_w = $clog2(frame_bits + 1);

   logic [frame_bits-1:0] shift_reg;
   logic [cnt_w-1:0]      bit_cnt;
   logic [div_width-1:0]  div_cnt;
   logic                  bit_tick;

   // end of the current bit period
   assign bit_tick = (bit_cnt != '0) && (div_cnt == divider);

   //////////////////////////////
   // bit timing
   //////////////////////////////

   // counts 1..divider while a frame is on the line
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         div_cnt <= '0;
      end else if (tx_load) begin
         div_cnt <= div_width'(1);
      end else if (bit_cnt != '0) begin
         if (div_cnt == divider) begin
            div_cnt <= div_width'(1);
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // bits left in the frame
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         bit_cnt <= '0;
      end else if (tx_load) begin
         bit_cnt <= cnt_w'(frame_bits);
      end else if (bit_tick) begin
         bit_cnt <= bit_cnt - 1'b1;
      end
   end

   //////////////////////////////
   // shift register
   //////////////////////////////

   // stop bit on top, start bit at the output, lsb first
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         shift_reg <= {frame_bits{line_idle}};
      end else if (tx_load) begin
         shift_reg <= {line_idle, tx_byte, ~line_idle};
      end else if (bit_tick) begin
         shift_reg <= {line_idle, shift_reg[frame_bits-1:1]};
      end
   end

   assign txd     = shift_reg[0];
   assign tx_busy = (bit_cnt != '0);

   // the line must rest at idle between frames
   a_idle_line: assert property (
      @(posedge clk) disable iff (rst_int) !tx_busy |-> txd == line_idle
   );

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
   parameter int div_width = 16
) (
   input  wire logic                                  clk,
   input  wire logic                                  rst_int,
   input  wire logic                                  rxd,
   input  wire logic                                  rx_read,
   input  wire logic [div_width-1:0]                  divider,
   output logic      [uart_frame_pkg::byte_bits-1:0]  rx_byte,
   output logic                                       rx_valid,
   output logic                                       rx_rts_ok
);

   import uart_frame_pkg::*;

   localparam int idx_w = $clog2(byte_bits) + 1;

   rx_state_e            state;
   logic [1:0]           rxd_sync;
   logic                 rxd_s;
   logic [div_width-1:0] div_cnt;
   logic [idx_w-1:0]     bit_idx;
   logic [byte_bits-1:0] shift_reg;
   logic                 half_done;
   logic                 bit_done;
   logic                 sample;
   logic                 store;

   // line comes from outside the clock domain
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         rxd_sync <= {2{line_idle}};
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
      end
   end

   assign rxd_s = rxd_sync[1];

   // half a period lands in the middle of the start bit
   assign half_done = {div_cnt, 1'b0} >= {1'b0, divider};
   assign bit_done  = div_cnt >= divider;
   assign sample    = (state == rx_data) && bit_done;
   assign store     = (state == rx_stop) && bit_done;

   //////////////////////////////
   // receive FSM
   //////////////////////////////

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state     <= rx_idle;
         div_cnt   <= '0;
         bit_idx   <= '0;
         rx_valid  <= 1'b0;
         rx_rts_ok <= 1'b1;
      end else begin
         div_cnt <= div_cnt + 1'b1;
         // buffer consumed, sender may go on
         if (rx_read) begin
            rx_valid  <= 1'b0;
            rx_rts_ok <= 1'b1;
         end
         case (state)
            rx_idle: begin
               div_cnt <= div_width'(1);
               if (rxd_s != line_idle) begin
                  state     <= rx_start;
                  rx_rts_ok <= 1'b0;
               end
            end
            rx_start: begin
               if (half_done) begin
                  state   <= rx_data;
                  div_cnt <= div_width'(1);
                  bit_idx <= '0;
               end
            end
            rx_data: begin
               if (bit_done) begin
                  div_cnt <= div_width'(1);
                  if (bit_idx == idx_w'(byte_bits - 1)) begin
                     state <= rx_stop;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end
            end
            rx_stop: begin
               // middle of the stop bit, byte is complete
               if (bit_done) begin
                  rx_valid <= 1'b1;
                  state    <= rx_idle;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // data path, lsb arrives first
   always_ff @(posedge clk) begin
      if (sample) begin
         shift_reg <= {rxd_s, shift_reg[byte_bits-1:1]};
      end
      if (store) begin
         rx_byte <= shift_reg;
      end
   end

   a_bit_idx_range: assert property (
      @(posedge clk) disable iff (rst_int) state == rx_data |-> bit_idx < idx_w'(byte_bits)
   );

endmodule

`default_nettype wire

/* uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
   parameter int div_width = 16
) (
   input  wire logic                                 clk,
   input  wire logic                                 rst_int,
   // processor side
   input  wire logic                                 valid,
   input  wire logic [uart_reg_pkg::addr_width-1:0]  address,
   input  wire logic [uart_reg_pkg::data_width-1:0]  wdata,
   input  wire logic                                 wstrb,
   output logic      [uart_reg_pkg::data_width-1:0]  rdata,
   output logic                                      ready,
   // serial side
   output logic                                      txd,
   input  wire logic                                 rxd,
   input  wire logic                                 cts,
   output logic                                      rts
);

   logic                 soft_rst;
   logic                 serial_rst;
   logic [div_width-1:0] divider;
   logic                 rx_en;
   logic                 tx_load;
   logic [7:0]           tx_byte;
   logic                 rx_read;
   logic                 tx_busy;
   logic [7:0]           rx_byte;
   logic                 rx_valid;
   logic                 rx_rts_ok;

   // soft reset only touches the serial side
   assign serial_rst = rst_int | soft_rst;

   uart_regs #(
      .div_width(div_width)
   ) u_regs (
      .clk       (clk),
      .rst_int   (rst_int),
      .serial_rst(serial_rst),
      .valid     (valid),
      .address   (address),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ready     (ready),
      .soft_rst  (soft_rst),
      .rx_en     (rx_en),
      .rts       (rts),
      .tx_load   (tx_load),
      .rx_read   (rx_read),
      .divider   (divider),
      .tx_byte   (tx_byte),
      .rx_valid  (rx_valid),
      .rx_rts_ok (rx_rts_ok),
      .rx_byte   (rx_byte),
      .tx_busy   (tx_busy),
      .cts       (cts)
   );

   uart_tx #(
      .div_width(div_width)
   ) u_tx (
      .clk    (clk),
      .rst_int(serial_rst),
      .tx_load(tx_load),
      .tx_byte(tx_byte),
      .divider(divider),
      .txd    (txd),
      .tx_busy(tx_busy)
   );

   uart_rx #(
      .div_width(div_width)
   ) u_rx (
      .clk      (clk),
      .rst_int  (serial_rst),
      .rxd      (rxd),
      .rx_read  (rx_read),
      .divider  (divider),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid),
      .rx_rts_ok(rx_rts_ok)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int period = 10
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // free running, period in ns
   always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

/* tb_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart;

   import uart_reg_pkg::*;

   localparam int div_width   = 16;
   localparam int frame_len   = 10;
   localparam int n_tests     = 6;
   localparam int max_div     = 20;
   localparam int frame_limit = 12 * frame_len * max_div;
   localparam int timeout_cyc = n_tests * frame_limit + 2000;

   logic                  clk;
   logic                  rst_int;
   logic                  valid;
   logic [addr_width-1:0] address;
   logic [data_width-1:0] wdata;
   logic                  wstrb;
   logic [data_width-1:0] rdata;
   logic                  ready;
   logic                  serial_line;
   logic                  cts;
   logic                  rts;

   int     error_count  = 0;
   int     test_errors  = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   int     cyc_count    = 0;
   int     div_val      = 1;
   integer seed;

   tb_clock_gen #(.period(10)) u_clk (.clk(clk));

   // txd loops straight back into rxd
   uart_top #(
      .div_width(div_width)
   ) DUT (
      .clk    (clk),
      .rst_int(rst_int),
      .valid  (valid),
      .address(address),
      .wdata  (wdata),
      .wstrb  (wstrb),
      .rdata  (rdata),
      .ready  (ready),
      .txd    (serial_line),
      .rxd    (serial_line),
      .cts    (cts),
      .rts    (rts)
   );

   always @(posedge clk) begin
      cyc_count <= cyc_count + 1;
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic value_error(input string msg);
      error_count++;
      test_errors++;
      $display("Fail at %0t: %s", $time, msg);
   endtask

   task automatic run_problem(input string msg);
      error_count++;
      test_errors++;
      $display("%s", msg);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      end
      test_errors = 0;
   endtask

   // line level expected in bit slot k of a frame
   function automatic logic frame_bit(input logic [7:0] b, input int k);
      if (k == 0) begin
         return 1'b0;
      end else if (k == frame_len - 1) begin
         return 1'b1;
      end
      return b[k-1];
   endfunction

   task automatic bus_write(input logic [addr_width-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      valid   = 1'b1;
      wstrb   = 1'b1;
      address = addr;
      wdata   = data;
      @(posedge clk);
      #1;
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   // rdata taken mid-cycle along with the cycle number
   task automatic bus_read(input logic [addr_width-1:0] addr,
                           output logic [31:0] data, output int cyc);
      @(posedge clk);
      #1;
      valid   = 1'b1;
      wstrb   = 1'b0;
      address = addr;
      @(negedge clk);
      data = rdata;
      cyc  = cyc_count;
      @(posedge clk);
      #1;
      valid = 1'b0;
   endtask

   // wait for the transmitter to be free, then hand it a byte
   task automatic send_byte(input logic [7:0] b);
      logic [31:0] d;
      int          c;
      int          waited;
      d      = 32'd1;
      waited = 0;
      while (d[0] && waited < frame_limit) begin
         bus_read(uart_write_wait, d, c);
         waited += 2;
      end
      assert (!d[0]) else run_problem("transmitter never became free, byte not sent");
      if (!d[0]) begin
         bus_write(uart_data, {24'd0, b});
      end
   endtask

   task automatic wait_rx(output logic got);
      logic [31:0] d;
      int          c;
      int          waited;
      d      = '0;
      waited = 0;
      while (!d[0] && waited < frame_limit) begin
         bus_read(uart_read_valid, d, c);
         waited += 2;
      end
      got = d[0];
   endtask

   // every access is answered exactly one cycle later
   a_ready_timing: assert property (
      @(posedge clk) disable iff (rst_int) ready == $past(valid)
   ) else value_error("ready did not follow valid by one cycle");

   //////////////////////////////
   // watchdog
   //////////////////////////////

   initial begin
      repeat (timeout_cyc) @(posedge clk);
      $display("watchdog expired: tests still running after %0d cycles", timeout_cyc);
      $display("Simulation failed");
      $finish;
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      logic [7:0]  tx_val;
      logic [31:0] rd;
      int          rc;
      int          cyc_e0;
      int          waited;
      logic        got;

      seed    = 85;
      rst_int = 1'b1;
      valid   = 1'b0;
      wstrb   = 1'b0;
      address = '0;
      wdata   = '0;
      cts     = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst_int = 1'b0;

      // reset state
      assert (ready == 1'b0) else value_error("ready high after reset");
      assert (serial_line == 1'b1) else value_error("txd not idle after reset");
      assert (rts == 1'b0) else value_error("rts high after reset");
      bus_read(uart_div, rd, rc);
      assert (rd == 32'd1) else value_error($sformatf("divider reads %0d, expected 1", rd));
      bus_read(uart_write_wait, rd, rc);
      assert (rd == 32'd0) else value_error("write wait set with cts high");
      finish_test("reset state");

      // divider register
      div_val = 4 + int'($unsigned($random(seed)) % 17);
      bus_write(uart_div, 32'(div_val));
      bus_read(uart_div, rd, rc);
      assert (rd == 32'(div_val))
         else value_error($sformatf("divider reads %0d, expected %0d", rd, div_val));
      finish_test("divider register");

      // transmit frame with bit centers and busy window
      tx_val = 8'($random(seed));
      send_byte(tx_val);
      cyc_e0 = cyc_count;
      fork
         begin : check_line
            for (int c = 0; c < frame_len * div_val; c++) begin
               @(negedge clk);
               if (c % div_val == div_val / 2) begin
                  assert (serial_line == frame_bit(tx_val, c / div_val))
                     else value_error($sformatf("txd wrong in bit %0d of byte %02h",
                                                c / div_val, tx_val));
               end
            end
         end
         begin : poll_busy
            int          pc;
            int          prc;
            logic [31:0] pd;
            pc = 0;
            while (pc <= frame_len * div_val) begin
               bus_read(uart_write_wait, pd, prc);
               pc = prc - cyc_e0;
               assert (pd[0] == (pc < frame_len * div_val))
                  else value_error($sformatf("write wait reads %0d at cycle %0d of frame",
                                             pd[0], pc));
            end
         end
      join
      finish_test("transmit frame");

      // loopback receive
      bus_write(uart_rxen, 32'd1);
      // byte from the frame above is still buffered
      bus_read(uart_data, rd, rc);
      bus_read(uart_read_valid, rd, rc);
      assert (rd == 32'd0) else value_error("read valid still set after data read");
      tx_val = 8'($random(seed));
      send_byte(tx_val);
      wait_rx(got);
      assert (got) else run_problem("receiver never reported the looped back byte");
      bus_read(uart_data, rd, rc);
      assert (rd[7:0] == tx_val)
         else value_error($sformatf("received %02h, sent %02h", rd[7:0], tx_val));
      bus_read(uart_read_valid, rd, rc);
      assert (rd == 32'd0) else value_error("read valid set after the byte was read");
      finish_test("loopback receive");

      // flow control
      @(posedge clk);
      #1;
      cts = 1'b0;
      repeat (3) @(posedge clk);
      bus_read(uart_write_wait, rd, rc);
      assert (rd[0] == 1'b1) else value_error("write wait clear with cts low");
      @(posedge clk);
      #1;
      cts = 1'b1;
      bus_write(uart_rxen, 32'd0);
      @(negedge clk);
      assert (rts == 1'b0) else value_error("rts high with rx disabled");
      bus_write(uart_rxen, 32'd1);
      @(negedge clk);
      assert (rts == 1'b1) else value_error("rts low with rx enabled and buffer empty");
      tx_val = 8'($random(seed));
      send_byte(tx_val);
      waited = 0;
      while (rts && waited < frame_limit) begin
         @(negedge clk);
         waited++;
      end
      assert (!rts) else run_problem("rts never dropped while a byte arrived");
      wait_rx(got);
      assert (got) else run_problem("receiver never reported the byte in flow control test");
      @(negedge clk);
      assert (rts == 1'b0) else value_error("rts high with an unread byte");
      bus_read(uart_data, rd, rc);
      assert (rd[7:0] == tx_val)
         else value_error($sformatf("received %02h, sent %02h", rd[7:0], tx_val));
      @(negedge clk);
      assert (rts == 1'b1) else value_error("rts did not return after the data read");
      finish_test("flow control");

      // soft reset in the middle of a frame with a byte waiting in the buffer
      tx_val = 8'($random(seed));
      send_byte(tx_val);
      wait_rx(got);
      assert (got) else run_problem("receiver never reported the byte before soft reset");
      // an all-zero byte holds the line low for most of the frame
      send_byte(8'h00);
      bus_write(uart_soft_reset, 32'd1);
      @(posedge clk);
      bus_read(uart_div, rd, rc);
      assert (rd == 32'd1) else value_error($sformatf("divider reads %0d after soft reset", rd));
      bus_read(uart_rxen, rd, rc);
      assert (rd == 32'd0) else value_error("rx enable still set after soft reset");
      bus_read(uart_read_valid, rd, rc);
      assert (rd == 32'd0) else value_error("read valid still set after soft reset");
      @(negedge clk);
      assert (rts == 1'b0) else value_error("rts high after soft reset");
      assert (serial_line == 1'b1) else value_error("txd not idle after soft reset");
      finish_test("soft reset");

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
uart_reg_pkg.sv
uart_frame_pkg.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_clock_gen.sv
tb_uart.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_uart -f all.f -o tb_uart_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_uart_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
   exit 0
fi
exit 1
